/* fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define RESET_PC 32'hBFC0_0000

// instruction address width
`define ADDR_W 32

// instruction bus data width, one dual-issue word
`define BUS_W 64

// instructions delivered per fetch
`define FETCH_SLOTS 2

// bytes consumed per fetch
`define PC_STEP 8

`endif

/* fetch_pkg.sv */
`include "fetch_macros.svh"

package fetch_pkg;

    // instruction bus request, held until addr_ok
    typedef struct packed {
        logic              valid;
        logic [`ADDR_W-1:0] addr;
    } ibus_req_t;

    // data follows addr_ok by one cycle
    typedef struct packed {
        logic              addr_ok;
        logic [`BUS_W-1:0] data;
    } ibus_resp_t;

    // resolved branch target from a later stage
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] target;
    } redirect_t;

    // F1 entry, waiting for its bus word
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] pc;
        logic               exc;
    } fetch1_t;

    // one instruction slot towards decode
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] pc;
        logic [31:0]        instr;
        logic               exc;
    } fetch_slot_t;

    // slot 1 holds the lower address
    typedef fetch_slot_t [`FETCH_SLOTS-1:0] fetch_pair_t;

endpackage

/* pc_gen.sv */
`timescale 1ns/100ps

`include "fetch_macros.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold,
    input  fetch_pkg::redirect_t  redirect,
    input  fetch_pkg::ibus_resp_t iresp,
    output fetch_pkg::ibus_req_t  ireq,
    output fetch_pkg::fetch1_t    f1_next
);

    // current fetch address
    logic [`ADDR_W-1:0] pc;
    logic [`ADDR_W-1:0] pc_next;
    logic [`ADDR_W-1:0] pc_succ;

    // low two bits set means the fetch cannot go to the bus
    logic misaligned;

    // request taken by the bus this cycle
    logic accept;

    // misaligned pc consumed without a bus request
    logic skip;

    assign misaligned = pc[1:0] != 2'b00;
    assign pc_succ    = pc + `ADDR_W'(`PC_STEP);

    // request path
    always_comb begin
        ireq.valid = ~hold & ~misaligned;
        ireq.addr  = pc;
    end

    assign accept = ireq.valid & iresp.addr_ok;
    assign skip   = misaligned & ~hold;

    // next pc selection, a redirect wins over stepping
    always_comb begin
        pc_next = pc;
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (accept || skip) begin
            pc_next = pc_succ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // F1 entry for the address leaving this stage
    // misaligned entries carry the exception flag instead of a bus word
    always_comb begin
        f1_next.pc  = pc;
        f1_next.exc = misaligned;
        if (redirect.valid) begin
            // the fetch on a redirect cycle belongs to the old path
            f1_next.valid = 1'b0;
        end else begin
            f1_next.valid = accept | skip;
        end
    end

endmodule

/* pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // stage contents
    T q_r;

    // flush drops the entry even when the stage is stalled
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q_r <= '0;
        end else if (en) begin
            q_r <= d;
        end
    end

    assign q = q_r;

endmodule

/* fetch_align.sv */
`timescale 1ns/100ps

`include "fetch_macros.svh"

module fetch_align (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::fetch1_t    f1,
    input  fetch_pkg::ibus_resp_t iresp,
    input  fetch_pkg::fetch_pair_t fetch_out,
    input  logic                  dec_ready,
    output logic                  hold,
    output fetch_pkg::fetch_pair_t pair_next
);

    // bus word kept while the output stage is stalled
    logic [`BUS_W-1:0] word_save;
    logic              word_saved;

    // word actually split into slots this cycle
    logic [`BUS_W-1:0] word;

    // first hold cycle with a live F1 entry
    logic capture;

    // decode is not taking a valid pair
    assign hold = fetch_out[`FETCH_SLOTS-1].valid & ~dec_ready;

    assign capture = hold & f1.valid & ~word_saved;

    always_ff @(posedge clk) begin
        if (reset) begin
            word_saved <= 1'b0;
        end else if (capture) begin
            word_saved <= 1'b1;
        end else if (!hold) begin
            word_saved <= 1'b0;
        end
    end

    // bus word from the first hold cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            word_save <= iresp.data;
        end
    end

    // the bus only returns the word once
    assign word = word_saved ? word_save : iresp.data;

    // slot split
    // slot FETCH_SLOTS-1 takes the low half at f1 pc,
    // slot 0 the high half at the highest address
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            pair_next[`FETCH_SLOTS-1-i].valid = f1.valid;
            pair_next[`FETCH_SLOTS-1-i].pc    = f1.pc + `ADDR_W'(4 * i);
            pair_next[`FETCH_SLOTS-1-i].exc   = f1.exc;
            if (f1.exc) begin
                // no bus word exists for a misaligned fetch
                pair_next[`FETCH_SLOTS-1-i].instr = 32'h0;
            end else begin
                pair_next[`FETCH_SLOTS-1-i].instr = word[32*i +: 32];
            end
        end
    end

endmodule

/* fetch_front.sv */
`timescale 1ns/100ps

module fetch_front (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::ibus_resp_t  iresp,
    input  fetch_pkg::redirect_t   redirect,
    input  logic                   dec_ready,
    output fetch_pkg::ibus_req_t   ireq,
    output fetch_pkg::fetch_pair_t fetch_out
);

    import fetch_pkg::*;

    // pc stage to F1 register
    fetch1_t f1_next;
    fetch1_t f1;

    // align stage to output register
    fetch_pair_t pair_next;

    // decode back-pressure, freezes both stages
    logic hold;

    pc_gen u_pc_gen (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .redirect (redirect),
        .iresp    (iresp),
        .ireq     (ireq),
        .f1_next  (f1_next)
    );

    // F1 entry waits here for its bus word
    pipe_reg #(
        .T (fetch1_t)
    ) u_f1_reg (
        .clk   (clk),
        .reset (reset),
        .en    (~hold),
        .flush (redirect.valid),
        .d     (f1_next),
        .q     (f1)
    );

    fetch_align u_fetch_align (
        .clk       (clk),
        .reset     (reset),
        .f1        (f1),
        .iresp     (iresp),
        .fetch_out (fetch_out),
        .dec_ready (dec_ready),
        .hold      (hold),
        .pair_next (pair_next)
    );

    // pair presented to decode
    pipe_reg #(
        .T (fetch_pair_t)
    ) u_out_reg (
        .clk   (clk),
        .reset (reset),
        .en    (~hold),
        .flush (redirect.valid),
        .d     (pair_next),
        .q     (fetch_out)
    );

endmodule

/* tb_fetch_front.sv */
`timescale 1ns/100ps

`include "fetch_macros.svh"

module tb_fetch_front;

    import fetch_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_PAIRS  = 400;
    localparam logic [31:0] SEED       = 32'd76793;

    logic        clk = 1'b0;
    logic        reset;
    ibus_resp_t  iresp;
    redirect_t   redirect;
    logic        dec_ready;
    ibus_req_t   ireq;
    fetch_pair_t fetch_out;

    // stimulus random state
    logic [31:0] rng;

    // reference state kept by the monitor
    logic [`ADDR_W-1:0] exp_pc;
    logic [`ADDR_W-1:0] req_pc;
    logic               acc_pending;
    logic [`ADDR_W-1:0] acc_addr;
    logic               held_prev;
    fetch_pair_t        held_pair;
    logic               first_cycle;

    int pair_count     = 0;
    int exc_pairs      = 0;
    int redirect_count = 0;
    int mismatch_count = 0;
    int other_count    = 0;

    fetch_front u_fetch_front (
        .clk       (clk),
        .reset     (reset),
        .iresp     (iresp),
        .redirect  (redirect),
        .dec_ready (dec_ready),
        .ireq      (ireq),
        .fetch_out (fetch_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // true for roughly pct percent of random values
    function automatic logic chance(input logic [31:0] r, input int pct);
        return (r % 100) < pct;
    endfunction

    // instruction stored at a word address as a hash of the whole address
    function automatic logic [31:0] mem_word(input logic [`ADDR_W-1:0] addr);
        logic [31:0] h;
        h = xorshift(addr ^ 32'h9E37_79B9);
        h = xorshift(h ^ 32'h85EB_CA6B);
        return h;
    endfunction

    // pair decode should receive for a fetch at pc
    function automatic fetch_pair_t expected_pair(input logic [`ADDR_W-1:0] pc);
        fetch_pair_t p;
        logic        exc;
        exc = pc[1:0] != 2'b00;
        // slot 1 is the lower address
        p[1].valid = 1'b1;
        p[1].pc    = pc;
        p[1].exc   = exc;
        p[1].instr = exc ? 32'h0 : mem_word(pc);
        p[0].valid = 1'b1;
        p[0].pc    = pc + 32'd4;
        p[0].exc   = exc;
        p[0].instr = exc ? 32'h0 : mem_word(pc + 32'd4);
        return p;
    endfunction

    task automatic check_pair(
        input fetch_pair_t got,
        input fetch_pair_t want,
        input string       name
    );
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            if (got[i] !== want[i]) begin
                $display("MISMATCH %s slot %0d: got %h expected %h",
                         name, i, got[i], want[i]);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_req(
        input ibus_req_t got,
        input ibus_req_t want,
        input string     name
    );
        if (got !== want) begin
            $display("MISMATCH %s: got valid %h addr %h expected valid %h addr %h",
                     name, got.valid, got.addr, want.valid, want.addr);
            mismatch_count++;
        end
    endtask

    // reference model and compare at mid-cycle
    always @(negedge clk) begin : monitor
        ibus_req_t   exp_req;
        logic        exp_hold;
        logic        exp_accept;
        fetch_pair_t exp_pair;
        if (reset) begin
            exp_pc      = `RESET_PC;
            req_pc      = `RESET_PC;
            acc_pending = 1'b0;
            acc_addr    = '0;
            held_prev   = 1'b0;
            held_pair   = '0;
            first_cycle = 1'b1;
        end else begin
            if (first_cycle) begin
                if (fetch_out[1].valid || fetch_out[0].valid) begin
                    $display("ERROR: fetch_out slot valid set right after reset");
                    other_count++;
                end
                first_cycle = 1'b0;
            end

            // decode stall freezes the front end
            exp_hold = fetch_out[1].valid & ~dec_ready;

            exp_req.valid = ~exp_hold & (req_pc[1:0] == 2'b00);
            exp_req.addr  = req_pc;
            check_req(ireq, exp_req, "ireq");

            // memory model sees what the bus really accepted
            exp_accept  = exp_req.valid & iresp.addr_ok;
            acc_pending = ireq.valid & iresp.addr_ok;
            acc_addr    = ireq.addr;
            if (acc_pending && ireq.addr[1:0] != 2'b00) begin
                $display("ERROR: bus accepted misaligned address %h", ireq.addr);
                other_count++;
            end

            if (held_prev) begin
                check_pair(fetch_out, held_pair, "fetch_out while held");
            end

            if (fetch_out[1].valid != fetch_out[0].valid) begin
                $display("ERROR: fetch_out slot valids disagree");
                other_count++;
            end

            // transfer to decode
            if (fetch_out[1].valid && dec_ready) begin
                exp_pair = expected_pair(exp_pc);
                check_pair(fetch_out, exp_pair, "fetch_out");
                if (exp_pair[1].exc) begin
                    exc_pairs++;
                end
                exp_pc = exp_pc + `ADDR_W'(`PC_STEP);
                pair_count++;
            end

            held_prev = exp_hold & ~redirect.valid;
            held_pair = fetch_out;

            // a redirect drops everything in flight
            if (redirect.valid) begin
                exp_pc = redirect.target;
                req_pc = redirect.target;
            end else if (exp_accept || (req_pc[1:0] != 2'b00 && !exp_hold)) begin
                req_pc = req_pc + `ADDR_W'(`PC_STEP);
            end
        end
    end

    initial begin : stimulus
        logic [`ADDR_W-1:0] target;
        logic [1:0]         low_bits;
        logic               path_misaligned;
        logic               fire;
        int                 redirect_mark;
        reset           = 1'b1;
        iresp           = '0;
        redirect        = '0;
        dec_ready       = 1'b0;
        rng             = SEED;
        path_misaligned = 1'b0;
        redirect_mark   = 0;
        target          = '0;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        while (pair_count < NUM_PAIRS) begin
            @(posedge clk);
            #1;

            // word for last cycle's accepted request or junk
            rng = xorshift(rng);
            if (acc_pending) begin
                iresp.data = {mem_word(acc_addr + 32'd4), mem_word(acc_addr)};
            end else begin
                iresp.data = {rng, ~rng};
            end
            rng = xorshift(rng);
            iresp.addr_ok = chance(rng, 70);
            rng = xorshift(rng);
            dec_ready = chance(rng, 70);

            redirect = '0;
            fire     = 1'b0;
            rng      = xorshift(rng);
            if (path_misaligned && pair_count - redirect_mark >= 4) begin
                // leave the exception path
                target          = rng & 32'hFFFF_FFF8;
                path_misaligned = 1'b0;
                fire            = 1'b1;
            end else if (!path_misaligned && pair_count - redirect_mark >= 4
                         && chance(rng, 4)) begin
                rng = xorshift(rng);
                if (redirect_count % 3 == 2) begin
                    low_bits = rng[1:0];
                    if (low_bits == 2'b00) begin
                        low_bits = 2'b10;
                    end
                    target          = {rng[31:2], low_bits};
                    path_misaligned = 1'b1;
                end else begin
                    target = rng & 32'hFFFF_FFF8;
                end
                fire = 1'b1;
            end

            if (fire) begin
                redirect.valid  = 1'b1;
                redirect.target = target;
                redirect_mark   = pair_count;
                redirect_count++;
            end
        end

        redirect = '0;
        repeat (2) @(posedge clk);

        if (redirect_count == 0 || exc_pairs == 0) begin
            $display("ERROR: no misaligned redirect reached decode during the run");
            other_count++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // about 40 cycles per pair
    initial begin : watchdog
        #(NUM_PAIRS * 40 * CLK_PERIOD);
        $display("ERROR: timeout with %0d of %0d pairs delivered to decode",
                 pair_count, NUM_PAIRS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
fetch_pkg.sv
pc_gen.sv
pipe_reg.sv
fetch_align.sv
fetch_front.sv
tb_fetch_front.sv

/* run.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_fetch_front -f filelist.f -o sim_fetch_front \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_fetch_front)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
